// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e

verilator --binary --timing --assert --top-module tb_cpu -f src.f -o tb_cpu_sim

status=0
./obj_dir/tb_cpu_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
exit 0

// ==== src.f ====
src/cpu_pkg.sv
src/alu.sv
src/bus_sequencer.sv
src/instr_decoder.sv
src/exec_unit.sv
src/cpu_top.sv
tests/tb_clock.sv
tests/tb_cpu_chk.sv
tests/tb_cpu.sv

// ==== src/alu.sv ====
`timescale 1ns/100ps

module alu
    import cpu_pkg::*;
(
    input  alu_op_t    op,
    input  logic [7:0] a,
    input  logic [7:0] b,
    output logic [7:0] result,
    output flags_t     flags
);

    logic [4:0] half;  // Nibble sum with the carry or borrow in bit 4
    logic [8:0] full;

    always_comb begin
        half   = '0;
        full   = '0;
        result = b;
        flags  = '0;
        case (op)
            ALU_ADD: begin
                half    = {1'b0, a[3:0]} + {1'b0, b[3:0]};
                full    = {1'b0, a} + {1'b0, b};
                result  = full[7:0];
                flags.h = half[4];
                flags.c = full[8];
            end
            ALU_SUB: begin
                half    = {1'b0, a[3:0]} - {1'b0, b[3:0]};
                full    = {1'b0, a} - {1'b0, b};
                result  = full[7:0];
                flags.n = 1'b1;
                flags.h = half[4];  // Borrow from bit 4
                flags.c = full[8];
            end
            ALU_AND: begin
                result  = a & b;
                flags.h = 1'b1;
            end
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = b;  // Pass of operand B
        endcase
        flags.z = (result == 8'h00);
    end

endmodule

// ==== src/bus_sequencer.sv ====
`timescale 1ns/100ps

module bus_sequencer
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cycle_ctrl_t ctrl,
    input  exec_state_t state,
    input  logic [7:0]  din,
    output ct_phase_t   ct,
    output logic [15:0] a,
    output logic [7:0]  dout,
    output logic        rd,
    output logic        wr,
    output logic        phi,
    output bus_sample_t sample
);

    logic [15:0] addr_next;
    logic        is_rd_op;
    logic [7:0]  sample_data;
    logic        sample_fetch;
    logic        sample_read;

    assign addr_next = (ctrl.addr_sel == ADDR_IMM) ? state.imm : state.pc;
    assign is_rd_op  = (ctrl.bus_op == BUS_FETCH) || (ctrl.bus_op == BUS_READ);

    ////////////////////////////////////////////////////////////////////////////
    // Phase counter and bus strobes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ct           <= CT_ADDR;
            a            <= 16'h0000;
            dout         <= 8'h00;
            rd           <= 1'b0;
            wr           <= 1'b0;
            phi          <= 1'b1;
            sample_fetch <= 1'b0;
            sample_read  <= 1'b0;
        end else begin
            ct           <= ct_phase_t'(ct + 2'd1);  // Free running
            sample_fetch <= 1'b0;
            sample_read  <= 1'b0;
            case (ct)
                CT_ADDR: begin
                    a   <= addr_next;
                    rd  <= is_rd_op;
                    wr  <= 1'b0;
                    phi <= 1'b1;
                end
                CT_DATA: begin
                    if (ctrl.bus_op == BUS_WRITE) begin
                        wr   <= 1'b1;
                        dout <= state.acc;
                    end
                    sample_fetch <= (ctrl.bus_op == BUS_FETCH);
                    sample_read  <= (ctrl.bus_op == BUS_READ);
                    rd           <= 1'b0;
                    phi          <= 1'b0;
                end
                CT_IDLE: begin
                    wr   <= 1'b0;  // One clock write pulse
                    dout <= 8'h00;
                end
                default: ;
            endcase
        end
    end

    // Read data is valid while a strobe is high
    always_ff @(posedge clk) begin
        if (ct == CT_DATA && is_rd_op) begin
            sample_data <= din;
        end
    end

    assign sample = '{data: sample_data, fetch: sample_fetch, read: sample_read};

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Machine cycle and bus types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CT_ADDR = 2'd0,  // Address set up, rd raised
        CT_WAIT = 2'd1,
        CT_DATA = 2'd2,  // Read data captured, wr raised
        CT_IDLE = 2'd3   // Results written back
    } ct_phase_t;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_FETCH = 2'd1,
        BUS_READ  = 2'd2,
        BUS_WRITE = 2'd3
    } bus_op_t;

    typedef enum logic {
        ADDR_PC  = 1'b0,
        ADDR_IMM = 1'b1
    } addr_sel_t;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,  // Result is operand B
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5
    } alu_op_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    // Control word for one machine cycle
    typedef struct packed {
        bus_op_t   bus_op;
        addr_sel_t addr_sel;
        alu_op_t   alu_op;
        logic      acc_we;
        logic      flags_we;
        logic      imm_lo_we;
        logic      imm_hi_we;
        logic      pc_inc;
        logic      pc_load;   // Wins over pc_inc
        logic      last;      // Final cycle of the instruction
    } cycle_ctrl_t;

    typedef struct packed {
        logic [7:0] data;
        logic       fetch;
        logic       read;
    } bus_sample_t;

    typedef struct packed {
        logic [15:0] pc;
        logic [15:0] imm;
        logic [7:0]  acc;
        flags_t      flags;
    } exec_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] OP_NOP      = 8'h00;
    localparam logic [7:0] OP_LD_A_D8  = 8'h3E;
    localparam logic [7:0] OP_ADD_D8   = 8'hC6;
    localparam logic [7:0] OP_SUB_D8   = 8'hD6;
    localparam logic [7:0] OP_AND_D8   = 8'hE6;
    localparam logic [7:0] OP_OR_D8    = 8'hF6;
    localparam logic [7:0] OP_XOR_D8   = 8'hEE;
    localparam logic [7:0] OP_LD_A16_A = 8'hEA;
    localparam logic [7:0] OP_JP       = 8'hC3;
    localparam logic [7:0] OP_JP_Z     = 8'hCA;
    localparam logic [7:0] OP_JP_C     = 8'hDA;
    localparam logic [7:0] OP_HALT     = 8'h76;

endpackage

// ==== src/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top
    import cpu_pkg::*;
#(
    parameter logic [15:0] RESET_VECTOR = 16'h0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic        phi,
    output ct_phase_t   ct,
    output logic [15:0] a,
    output logic [7:0]  dout,
    input  logic [7:0]  din,
    output logic        rd,
    output logic        wr,
    output logic        done
);

    cycle_ctrl_t ctrl;    // Decoder to sequencer and execution unit
    bus_sample_t sample;  // Captured read data
    exec_state_t state;   // Register file view

    instr_decoder u_decoder (
        .clk    (clk),
        .rst    (rst),
        .ct     (ct),
        .sample (sample),
        .state  (state),
        .ctrl   (ctrl),
        .done   (done)
    );

    bus_sequencer u_sequencer (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (ctrl),
        .state  (state),
        .din    (din),
        .ct     (ct),
        .a      (a),
        .dout   (dout),
        .rd     (rd),
        .wr     (wr),
        .phi    (phi),
        .sample (sample)
    );

    exec_unit #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_exec (
        .clk    (clk),
        .rst    (rst),
        .ct     (ct),
        .ctrl   (ctrl),
        .sample (sample),
        .state  (state)
    );

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit
    import cpu_pkg::*;
#(
    parameter logic [15:0] RESET_VECTOR = 16'h0000
) (
    input  logic        clk,
    input  logic        rst,
    input  ct_phase_t   ct,
    input  cycle_ctrl_t ctrl,
    input  bus_sample_t sample,
    output exec_state_t state
);

    logic [15:0] pc;
    logic [15:0] imm;
    logic [15:0] imm_next;
    logic [7:0]  acc;
    logic [7:0]  alu_result;
    flags_t      flags;
    flags_t      alu_flags;
    logic        apply;

    // Write back happens only in the idle phase
    assign apply = (ct == CT_IDLE);

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (acc),
        .b      (sample.data),
        .result (alu_result),
        .flags  (alu_flags)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Immediate register
    ////////////////////////////////////////////////////////////////////////////

    // Next value lets JP load the high byte on the same edge it arrives
    always_comb begin
        imm_next = imm;
        if (ctrl.imm_lo_we && sample.read) begin
            imm_next[7:0] = sample.data;
        end
        if (ctrl.imm_hi_we && sample.read) begin
            imm_next[15:8] = sample.data;
        end
    end

    always_ff @(posedge clk) begin
        if (apply) begin
            imm <= imm_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Architectural registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= RESET_VECTOR;
            acc   <= 8'h00;
            flags <= '0;
        end else if (apply) begin
            if (ctrl.acc_we && sample.read) begin  // Operand byte from the read
                acc <= alu_result;
            end
            if (ctrl.flags_we && sample.read) begin
                flags <= alu_flags;
            end
            if (ctrl.pc_load) begin
                pc <= imm_next;        // Jump target
            end else if (ctrl.pc_inc) begin
                pc <= pc + 16'd1;
            end
        end
    end

    assign state = '{pc: pc, imm: imm, acc: acc, flags: flags};

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ct_phase_t   ct,
    input  bus_sample_t sample,
    input  exec_state_t state,
    output cycle_ctrl_t ctrl,
    output logic        done
);

    logic [7:0] opcode;
    logic [7:0] op_now;     // Opcode seen by this cycle's control word
    logic [1:0] mcyc;
    logic       halted;
    logic       is_alu;
    logic       is_ld_imm;
    logic       is_jump;
    logic       is_store;
    logic       jump_taken;
    alu_op_t    imm_op;

    // Fetched byte is only in sample during the fetch's idle phase
    assign op_now = sample.fetch ? sample.data : opcode;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode classes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        imm_op = ALU_PASS;
        is_alu = 1'b1;
        case (op_now)
            OP_ADD_D8: imm_op = ALU_ADD;
            OP_SUB_D8: imm_op = ALU_SUB;
            OP_AND_D8: imm_op = ALU_AND;
            OP_OR_D8:  imm_op = ALU_OR;
            OP_XOR_D8: imm_op = ALU_XOR;
            default:   is_alu = 1'b0;
        endcase
    end

    assign is_ld_imm  = (op_now == OP_LD_A_D8);
    assign is_store   = (op_now == OP_LD_A16_A);
    assign is_jump    = (op_now == OP_JP) || (op_now == OP_JP_Z) || (op_now == OP_JP_C);
    assign jump_taken = (op_now == OP_JP)
                     || ((op_now == OP_JP_Z) && state.flags.z)
                     || ((op_now == OP_JP_C) && state.flags.c);

    // Control word for the current machine cycle
    always_comb begin
        ctrl = '0;
        if (halted) begin
            ctrl.last = 1'b1;  // Hold cycle counter at zero
        end else begin
            case (mcyc)
                2'd0: begin
                    ctrl.bus_op = BUS_FETCH;
                    ctrl.pc_inc = 1'b1;
                    ctrl.last   = !(is_alu || is_ld_imm || is_jump || is_store);
                end
                2'd1: begin
                    ctrl.bus_op = BUS_READ;
                    ctrl.pc_inc = 1'b1;
                    if (is_alu || is_ld_imm) begin
                        ctrl.alu_op   = imm_op;
                        ctrl.acc_we   = 1'b1;
                        ctrl.flags_we = is_alu;  // LD leaves flags alone
                        ctrl.last     = 1'b1;
                    end else begin
                        ctrl.imm_lo_we = 1'b1;
                    end
                end
                2'd2: begin
                    ctrl.bus_op    = BUS_READ;
                    ctrl.pc_inc    = 1'b1;
                    ctrl.imm_hi_we = 1'b1;
                    ctrl.pc_load   = is_jump && jump_taken;
                    ctrl.last      = is_jump;
                end
                default: begin
                    ctrl.bus_op   = BUS_WRITE;  // Store of A
                    ctrl.addr_sel = ADDR_IMM;
                    ctrl.last     = 1'b1;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mcyc   <= 2'd0;
            halted <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= halted;
            if (ct == CT_IDLE) begin
                mcyc <= ctrl.last ? 2'd0 : mcyc + 2'd1;
                if (!halted && mcyc == 2'd0 && op_now == OP_HALT) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample.fetch) begin
            opcode <= sample.data;
        end
    end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_PERIOD = 10  // 20 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// ==== tests/tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu
    import cpu_pkg::*;
();

    localparam logic [15:0] RESET_VECTOR = 16'h0100;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
    } mem_write_t;

    logic        clk;
    logic        rst;
    logic        phi;
    ct_phase_t   ct;
    logic [15:0] a;
    logic [7:0]  dout;
    logic [7:0]  din = 8'h00;
    logic        rd;
    logic        wr;
    logic        done;

    logic [7:0]  mem [0:65535];
    logic [15:0] prog_addr;
    logic [15:0] rd_addrs [$];  // Address at the start of each rd pulse
    mem_write_t  wr_log [$];
    int          rd_len = 0;
    int          wr_len = 0;
    logic [7:0]  ref_acc;
    flags_t      ref_flags;

    tb_clock u_clock (.clk(clk));

    cpu_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) dut (
        .clk  (clk),
        .rst  (rst),
        .phi  (phi),
        .ct   (ct),
        .a    (a),
        .dout (dout),
        .din  (din),
        .rd   (rd),
        .wr   (wr),
        .done (done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Error handling and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else
            abort_run($sformatf("FAILED at %0t ns: %s expected 0x%0h, actual 0x%0h",
                                $time, name, exp, act));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory model and bus monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : bus_monitor
        mem_write_t w;
        #2;
        din = rd ? mem[a] : 8'h00;  // Answers within the data phase
        assert (dut.u_chk.fail_count == 0) else
            abort_run("A bus protocol assertion in the bound checker fired");
        if (rd) begin
            if (rd_len == 0) begin
                rd_addrs.push_back(a);
            end
            rd_len++;
        end else if (rd_len != 0) begin
            check_value("rd pulse length", 32'd2, 32'(rd_len));
            rd_len = 0;
        end
        if (wr) begin
            if (wr_len == 0) begin
                w.addr = a;
                w.data = dout;
                wr_log.push_back(w);
            end
            wr_len++;
        end else if (wr_len != 0) begin
            check_value("wr pulse length", 32'd1, 32'(wr_len));
            wr_len = 0;
        end
    end

    task automatic fill_memory();
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[16'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'h3C;
        end
    endtask

    task automatic emit(input logic [7:0] b);
        mem[prog_addr] = b;
        prog_addr = prog_addr + 16'd1;
    endtask

    task automatic emit_d8(input logic [7:0] op, input logic [7:0] val);
        emit(op);
        emit(val);
    endtask

    task automatic emit_a16(input logic [7:0] op, input logic [15:0] addr);
        emit(op);
        emit(addr[7:0]);   // Little endian
        emit(addr[15:8]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of A and F
    ////////////////////////////////////////////////////////////////////////////

    function automatic void ref_step(input logic [7:0] op, input logic [7:0] operand);
        int         sum;
        int         lo;
        logic [7:0] res;
        flags_t     f;
        f = '0;
        res = operand;
        case (op)
            OP_ADD_D8: begin
                sum = int'(ref_acc) + int'(operand);
                lo = int'(ref_acc[3:0]) + int'(operand[3:0]);
                res = 8'(sum);
                f.h = (lo > 15);
                f.c = (sum > 255);
            end
            OP_SUB_D8: begin
                res = ref_acc - operand;
                f.n = 1'b1;
                f.h = (ref_acc[3:0] < operand[3:0]);
                f.c = (ref_acc < operand);
            end
            OP_AND_D8: begin
                res = ref_acc & operand;
                f.h = 1'b1;
            end
            OP_OR_D8:  res = ref_acc | operand;
            OP_XOR_D8: res = ref_acc ^ operand;
            default:   res = operand;  // LD A,d8
        endcase
        f.z = (res == 8'h00);
        ref_acc = res;
        if (op != OP_LD_A_D8) begin
            ref_flags = f;
        end
    endfunction

    function automatic logic [7:0] pick_imm_op(input int k);
        case (k)
            0:       return OP_LD_A_D8;
            1:       return OP_ADD_D8;
            2:       return OP_SUB_D8;
            3:       return OP_AND_D8;
            4:       return OP_OR_D8;
            default: return OP_XOR_D8;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing helpers
    ////////////////////////////////////////////////////////////////////////////

    // Runs 2 ns after a rising edge and leaves reset asserted
    task automatic begin_test();
        int i;
        rst = 1'b1;
        rd_addrs.delete();
        wr_log.delete();
        fill_memory();
        ref_acc = 8'h00;
        ref_flags = '0;
        prog_addr = RESET_VECTOR;
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic release_reset();
        rst = 1'b0;
    endtask

    task automatic wait_for_done(input int max_cycles);
        int n;
        n = 0;
        while (done !== 1'b1) begin
            assert (n < max_cycles) else abort_run("Timeout while waiting for done");
            @(posedge clk);
            #2;
            n++;
        end
    endtask

    task automatic wait_for_rd(input int max_cycles);
        int n;
        n = 0;
        while (rd !== 1'b1) begin
            assert (n < max_cycles) else abort_run("Timeout while waiting for rd");
            @(posedge clk);
            #2;
            n++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_and_first_fetch();
        int width;
        begin_test();
        emit(OP_HALT);
        check_value("rd", 32'd0, 32'(rd));
        check_value("wr", 32'd0, 32'(wr));
        check_value("done", 32'd0, 32'(done));
        check_value("dout", 32'd0, 32'(dout));
        check_value("phi", 32'd1, 32'(phi));
        check_value("ct", 32'(CT_ADDR), 32'(ct));
        release_reset();
        wait_for_rd(20);
        check_value("first fetch address", 32'(RESET_VECTOR), 32'(a));
        width = 0;
        while (rd === 1'b1) begin
            assert (width < 10) else abort_run("rd stuck high on the first fetch");
            width++;
            @(posedge clk);
            #2;
        end
        check_value("first rd pulse length", 32'd2, 32'(width));
        wait_for_done(100);
    endtask

    task automatic alu_store_program(input int pairs);
        mem_write_t  expected [$];
        mem_write_t  w;
        logic [7:0]  op;
        logic [7:0]  val;
        logic [15:0] addr;
        int          i;
        begin_test();
        for (i = 0; i < pairs; i++) begin
            op = pick_imm_op($urandom_range(0, 5));
            val = 8'($urandom);
            addr = {1'b1, 15'($urandom)};  // Stores stay clear of the code
            emit_d8(op, val);
            emit_a16(OP_LD_A16_A, addr);
            ref_step(op, val);
            w.addr = addr;
            w.data = ref_acc;
            expected.push_back(w);
        end
        emit(OP_HALT);
        release_reset();
        wait_for_done(40 * pairs + 100);
        check_value("write count", 32'(expected.size()), 32'(wr_log.size()));
        for (i = 0; i < expected.size(); i++) begin
            check_value("write address", 32'(expected[i].addr), 32'(wr_log[i].addr));
            check_value("write data", 32'(expected[i].data), 32'(wr_log[i].data));
        end
    endtask

    task automatic absolute_jump();
        logic [15:0] target;
        begin_test();
        target = {3'b001, 13'($urandom)};
        emit_a16(OP_JP, target);
        mem[target] = OP_HALT;
        release_reset();
        wait_for_done(100);
        check_value("fetch count", 32'd4, 32'(rd_addrs.size()));
        check_value("fetch after JP", 32'(target), 32'(rd_addrs[3]));
    endtask

    task automatic jp_cond_trial(input logic [7:0] jp_op, input logic [7:0] x,
                                 input logic [7:0] alu_op, input logic [7:0] y);
        logic [15:0] target;
        logic [15:0] next_fetch;
        logic        taken;
        begin_test();
        target = {3'b010, 13'($urandom)};
        emit_d8(OP_LD_A_D8, x);
        emit_d8(alu_op, y);
        emit_a16(jp_op, target);
        emit(OP_HALT);  // Fall through path
        mem[target] = OP_HALT;
        ref_step(OP_LD_A_D8, x);
        ref_step(alu_op, y);
        taken = (jp_op == OP_JP_Z) ? ref_flags.z : ref_flags.c;
        next_fetch = taken ? target : RESET_VECTOR + 16'd7;
        release_reset();
        wait_for_done(200);
        check_value("fetch count", 32'd8, 32'(rd_addrs.size()));
        check_value("fetch after JP cc", 32'(next_fetch), 32'(rd_addrs[7]));
    endtask

    task automatic conditional_jumps();
        logic [7:0] jp_op;
        int         i;
        jp_cond_trial(OP_JP_Z, 8'h5A, OP_SUB_D8, 8'h5A);  // Zero result
        jp_cond_trial(OP_JP_Z, 8'h5A, OP_XOR_D8, 8'h5B);
        jp_cond_trial(OP_JP_C, 8'h10, OP_SUB_D8, 8'h20);  // Borrow
        jp_cond_trial(OP_JP_C, 8'h01, OP_ADD_D8, 8'h01);
        for (i = 0; i < 12; i++) begin
            jp_op = ($urandom_range(0, 1) == 0) ? OP_JP_Z : OP_JP_C;
            jp_cond_trial(jp_op, 8'($urandom), pick_imm_op($urandom_range(1, 5)),
                          8'($urandom));
        end
    endtask

    task automatic halt_stops_bus();
        int i;
        int fetches;
        begin_test();
        emit(OP_NOP);
        emit(OP_NOP);
        emit(OP_NOP);
        emit(OP_HALT);
        release_reset();
        wait_for_done(200);
        fetches = rd_addrs.size();
        check_value("fetches up to HALT", 32'd4, 32'(fetches));
        for (i = 0; i < 200; i++) begin  // 50 machine cycles
            @(posedge clk);
            #2;
            check_value("rd while halted", 32'd0, 32'(rd));
        end
        check_value("rd pulses after HALT", 32'(fetches), 32'(rd_addrs.size()));
    endtask

    initial begin
        int i;
        rst = 1'b1;
        prog_addr = RESET_VECTOR;
        void'($urandom(55305));
        @(posedge clk);
        #2;
        reset_and_first_fetch();
        for (i = 0; i < 4; i++) begin
            absolute_jump();
        end
        for (i = 0; i < 3; i++) begin
            alu_store_program(10);
        end
        conditional_jumps();
        halt_stops_bus();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== tests/tb_cpu_chk.sv ====
`timescale 1ns/100ps

module tb_cpu_chk
    import cpu_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      rd,
    input logic      wr,
    input logic      done,
    input ct_phase_t ct
);

    int fail_count = 0;  // Polled by the testbench bus monitor

    ////////////////////////////////////////////////////////////////////////////
    // Bus protocol
    ////////////////////////////////////////////////////////////////////////////

    rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(rd && wr)
    ) else begin
        fail_count++;
        $error("rd and wr are high in the same cycle");
    end

    wr_in_idle_phase: assert property (
        @(posedge clk) disable iff (rst) wr |-> (ct == CT_IDLE)
    ) else begin
        fail_count++;
        $error("wr is high outside phase 3");
    end

    // Sticky until the next reset
    done_holds: assert property (
        @(posedge clk) disable iff (rst) done |=> done
    ) else begin
        fail_count++;
        $error("done fell without a reset");
    end

endmodule

bind cpu_top tb_cpu_chk u_chk (
    .clk  (clk),
    .rst  (rst),
    .rd   (rd),
    .wr   (wr),
    .done (done),
    .ct   (ct)
);
